//--- rv_pkg.sv
package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  // rv32i major opcodes
  typedef enum logic [6:0] {
    op     = 7'b0110011,
    op_imm = 7'b0010011,
    load   = 7'b0000011,
    store  = 7'b0100011,
    branch = 7'b1100011,
    lui    = 7'b0110111,
    auipc  = 7'b0010111,
    jal    = 7'b1101111,
    jalr   = 7'b1100111
  } opcode_e;

  typedef enum logic [2:0] {
    r_type = 3'd0,
    i_type = 3'd1,
    s_type = 3'd2,
    b_type = 3'd3,
    u_type = 3'd4,
    j_type = 3'd5
  } encoding_e;

  // values follow funct3 of the branch instructions
  typedef enum logic [2:0] {
    branch_beq  = 3'b000,
    branch_bne  = 3'b001,
    branch_blt  = 3'b100,
    branch_bge  = 3'b101,
    branch_bltu = 3'b110,
    branch_bgeu = 3'b111
  } branch_type_e;

  // alu codes line up with {funct7[5], funct3} where possible
  typedef enum logic [3:0] {
    alu_add    = 4'b0000,
    alu_sll    = 4'b0001,
    alu_slt    = 4'b0010,
    alu_sltu   = 4'b0011,
    alu_xor    = 4'b0100,
    alu_srl    = 4'b0101,
    alu_or     = 4'b0110,
    alu_and    = 4'b0111,
    alu_sub    = 4'b1000,
    alu_pass_b = 4'b1001,
    alu_sra    = 4'b1101
  } alu_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_view_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_view_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_view_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_view_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_view_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_view_t;

  // one instruction word, seen through each format
  typedef union packed {
    r_view_t r;
    i_view_t i;
    s_view_t s;
    b_view_t b;
    u_view_t u;
    j_view_t j;
  } instr_u;

  // all zero means bubble
  typedef struct packed {
    encoding_e    encoding;
    branch_type_e branch_type;
    logic         reg_write;
    logic         mem_read;
    logic         mem_write;
    logic         mem_to_reg;
    logic         alu_src;
    alu_op_e      alu_op;
  } control_t;

  typedef struct packed {
    logic                  reg_write;
    logic [reg_addr_w-1:0] write_id;
    logic [xlen-1:0]       write_data;
  } wb_t;

  typedef struct packed {
    logic                  mem_read;
    logic [reg_addr_w-1:0] rd;
  } id_ex_t;

endpackage

//--- decode_control.sv
`timescale 1ns/1ps

module decode_control
  import rv_pkg::*;
(
  input  instr_u   instruction,
  output control_t control
);

  // alu operation from funct3, alt is funct7[5]
  function automatic alu_op_e alu_from_funct(
    input logic [2:0] funct3,
    input logic       alt,
    input logic       is_reg
  );
    alu_op_e result;
    case (funct3)
      3'b000: begin
        // sub only exists in the register form
        result = (is_reg && alt) ? alu_sub : alu_add;
      end
      3'b001: result = alu_sll;
      3'b010: result = alu_slt;
      3'b011: result = alu_sltu;
      3'b100: result = alu_xor;
      3'b101: result = alt ? alu_sra : alu_srl;
      3'b110: result = alu_or;
      default: result = alu_and;
    endcase
    return result;
  endfunction

  always_comb begin
    control = '0;
    case (instruction.r.opcode)
      op: begin
        control.encoding  = r_type;
        control.reg_write = 1'b1;
        control.alu_op    = alu_from_funct(instruction.r.funct3, instruction.r.funct7[5], 1'b1);
      end
      op_imm: begin
        control.encoding  = i_type;
        control.reg_write = 1'b1;
        control.alu_src   = 1'b1;
        control.alu_op    = alu_from_funct(instruction.r.funct3, instruction.r.funct7[5], 1'b0);
      end
      load: begin
        control.encoding   = i_type;
        control.reg_write  = 1'b1;
        control.mem_read   = 1'b1;
        control.mem_to_reg = 1'b1;
        control.alu_src    = 1'b1;
        control.alu_op     = alu_add;
      end
      store: begin
        control.encoding  = s_type;
        control.mem_write = 1'b1;
        control.alu_src   = 1'b1;
        control.alu_op    = alu_add;
      end
      branch: begin
        control.encoding    = b_type;
        control.branch_type = branch_type_e'(instruction.r.funct3);
        control.alu_op      = alu_sub;
      end
      lui: begin
        control.encoding  = u_type;
        control.reg_write = 1'b1;
        control.alu_src   = 1'b1;
        control.alu_op    = alu_pass_b;
      end
      auipc: begin
        // execute adds pc and imm
        control.encoding  = u_type;
        control.reg_write = 1'b1;
        control.alu_src   = 1'b1;
        control.alu_op    = alu_add;
      end
      jal: begin
        control.encoding  = j_type;
        control.reg_write = 1'b1;
        control.alu_op    = alu_add;
      end
      jalr: begin
        control.encoding  = i_type;
        control.reg_write = 1'b1;
        control.alu_src   = 1'b1;
        control.alu_op    = alu_add;
      end
      default: begin
        control = '0;
      end
    endcase
  end

endmodule

//--- imm_gen.sv
`timescale 1ns/1ps

module imm_gen
  import rv_pkg::*;
(
  input  instr_u          instruction,
  input  encoding_e       encoding,
  output logic [xlen-1:0] imm
);

  always_comb begin
    case (encoding)
      i_type: begin
        imm = {{(xlen-12){instruction.i.imm_11_0[11]}}, instruction.i.imm_11_0};
      end
      s_type: begin
        imm = {{(xlen-12){instruction.s.imm_11_5[6]}},
               instruction.s.imm_11_5,
               instruction.s.imm_4_0};
      end
      b_type: begin
        // byte offset, bit 0 always zero
        imm = {{(xlen-13){instruction.b.imm_12}},
               instruction.b.imm_12,
               instruction.b.imm_11,
               instruction.b.imm_10_5,
               instruction.b.imm_4_1,
               1'b0};
      end
      u_type: begin
        imm = {instruction.u.imm_31_12, 12'b0};
      end
      j_type: begin
        imm = {{(xlen-21){instruction.j.imm_20}},
               instruction.j.imm_20,
               instruction.j.imm_19_12,
               instruction.j.imm_11,
               instruction.j.imm_10_1,
               1'b0};
      end
      default: begin
        // r-type has no immediate
        imm = '0;
      end
    endcase
  end

endmodule

//--- register_file.sv
`timescale 1ns/1ps

module register_file
  import rv_pkg::*;
#(
  parameter int reg_count = 32
) (
  input  logic                  clk,
  input  logic                  reset,
  input  wb_t                   wb,
  input  logic [reg_addr_w-1:0] read1_id,
  input  logic [reg_addr_w-1:0] read2_id,
  output logic [xlen-1:0]       read1_data,
  output logic [xlen-1:0]       read2_data
);

  // 4 index bits for rv32e, upper bit dropped
  localparam int idx_w = $clog2(reg_count);

  logic [xlen-1:0]  regs [reg_count];
  logic [idx_w-1:0] write_idx;
  logic [idx_w-1:0] read1_idx;
  logic [idx_w-1:0] read2_idx;

  assign write_idx = wb.write_id[idx_w-1:0];
  assign read1_idx = read1_id[idx_w-1:0];
  assign read2_idx = read2_id[idx_w-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      regs <= '{default: '0};
    end else if (wb.reg_write && (write_idx != '0)) begin
      regs[write_idx] <= wb.write_data;
    end
  end

  // x0 first, then write-through, then the array
  function automatic logic [xlen-1:0] read_port(input logic [idx_w-1:0] idx);
    logic [xlen-1:0] value;
    if (idx == '0) begin
      value = '0;
    end else if (wb.reg_write && (idx == write_idx)) begin
      value = wb.write_data;
    end else begin
      value = regs[idx];
    end
    return value;
  endfunction

  always_comb begin
    read1_data = read_port(read1_idx);
    read2_data = read_port(read2_idx);
  end

endmodule

//--- hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit
  import rv_pkg::*;
(
  input  instr_u instruction,
  input  id_ex_t id_ex,
  output logic   pc_write,
  output logic   fetch_write,
  output logic   make_bubble
);

  logic rd_nonzero;
  logic src_match;
  logic load_use;

  assign rd_nonzero = (id_ex.rd != '0);

  // rs2 is compared for every format
  assign src_match = (id_ex.rd == instruction.r.rs1) || (id_ex.rd == instruction.r.rs2);

  // load in execute feeding this instruction
  assign load_use = id_ex.mem_read && rd_nonzero && src_match;

  // hold pc and fetch register, bubble into execute
  assign pc_write    = !load_use;
  assign fetch_write = !load_use;
  assign make_bubble = load_use;

endmodule

//--- branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve
  import rv_pkg::*;
(
  input  control_t        control,
  input  logic [xlen-1:0] data1,
  input  logic [xlen-1:0] data2,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] imm,
  output logic            pc_src,
  output logic [xlen-1:0] pc_branch
);

  logic equal;
  logic less_signed;
  logic less_unsigned;

  assign equal         = (data1 == data2);
  assign less_signed   = ($signed(data1) < $signed(data2));
  assign less_unsigned = (data1 < data2);

  always_comb begin
    pc_src = 1'b0;
    if (control.encoding == b_type) begin
      case (control.branch_type)
        branch_beq:  pc_src = equal;
        branch_bne:  pc_src = !equal;
        branch_blt:  pc_src = less_signed;
        branch_bge:  pc_src = !less_signed;
        branch_bltu: pc_src = less_unsigned;
        branch_bgeu: pc_src = !less_unsigned;
        // funct3 010 and 011 are not branches
        default:     pc_src = 1'b0;
      endcase
    end
  end

  // imm already holds the byte offset
  assign pc_branch = pc + imm;

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage
  import rv_pkg::*;
#(
  parameter int reg_count = 32
) (
  input  logic                  clk,
  input  logic                  reset,
  input  instr_u                instruction,
  input  logic [xlen-1:0]       pc,
  input  wb_t                   wb,
  input  id_ex_t                id_ex,
  output logic [xlen-1:0]       data1,
  output logic [xlen-1:0]       data2,
  output logic [xlen-1:0]       imm,
  output logic [reg_addr_w-1:0] rd,
  output logic [reg_addr_w-1:0] rs1,
  output logic [reg_addr_w-1:0] rs2,
  output control_t              control,
  output logic [xlen-1:0]       pc_out,
  output logic [xlen-1:0]       pc_branch,
  output logic                  pc_src,
  output logic                  pc_write,
  output logic                  fetch_write
);

  control_t raw_control;
  logic     make_bubble;

  decode_control u_decode_control (
    .instruction (instruction),
    .control     (raw_control)
  );

  imm_gen u_imm_gen (
    .instruction (instruction),
    .encoding    (raw_control.encoding),
    .imm         (imm)
  );

  register_file #(
    .reg_count (reg_count)
  ) u_register_file (
    .clk        (clk),
    .reset      (reset),
    .wb         (wb),
    .read1_id   (instruction.r.rs1),
    .read2_id   (instruction.r.rs2),
    .read1_data (data1),
    .read2_data (data2)
  );

  hazard_unit u_hazard_unit (
    .instruction (instruction),
    .id_ex       (id_ex),
    .pc_write    (pc_write),
    .fetch_write (fetch_write),
    .make_bubble (make_bubble)
  );

  // a bubble carries no control and so cannot branch
  assign control = make_bubble ? '0 : raw_control;

  branch_resolve u_branch_resolve (
    .control   (control),
    .data1     (data1),
    .data2     (data2),
    .pc        (pc),
    .imm       (imm),
    .pc_src    (pc_src),
    .pc_branch (pc_branch)
  );

  // register fields sit at fixed positions in every format
  assign rs1    = instruction.r.rs1;
  assign rs2    = instruction.r.rs2;
  assign rd     = instruction.r.rd;
  assign pc_out = pc;

endmodule

//--- decode_stage_sva.sv
`timescale 1ns/1ps

module decode_stage_sva
  import rv_pkg::*;
(
  input logic     clk,
  input logic     reset,
  input control_t control,
  input logic     pc_src,
  input logic     pc_write,
  input logic     fetch_write
);

  // count of failed assertions, watched by the testbench
  int unsigned failures = 0;

  // a load-use stall must look like a bubble
  property stall_is_bubble;
    @(posedge clk) disable iff (reset) !pc_write |-> (control == '0) && !pc_src;
  endproperty

  property stall_lines_agree;
    @(posedge clk) disable iff (reset) pc_write == fetch_write;
  endproperty

  // only conditional branches redirect fetch here
  property taken_only_on_branch;
    @(posedge clk) disable iff (reset) pc_src |-> control.encoding == b_type;
  endproperty

  assert property (stall_is_bubble) else begin
    $error("stall with live control or taken branch");
    failures++;
  end
  assert property (stall_lines_agree) else begin
    $error("pc_write and fetch_write differ");
    failures++;
  end
  assert property (taken_only_on_branch) else begin
    $error("pc_src raised by a non-branch");
    failures++;
  end

endmodule

bind decode_stage decode_stage_sva u_decode_stage_sva (
  .clk         (clk),
  .reset       (reset),
  .control     (control),
  .pc_src      (pc_src),
  .pc_write    (pc_write),
  .fetch_write (fetch_write)
);

//--- tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage
  import rv_pkg::*;
();

  // one check per driven cycle, summed over the test loops below
  localparam int num_tests = 16 + 31 + 2 + 16 + 40 + 600 + 8 + 300 + 200;

  typedef struct packed {
    logic [xlen-1:0] imm;
    logic [xlen-1:0] data1;
    logic [xlen-1:0] data2;
    control_t        control;
    logic            pc_src;
    logic [xlen-1:0] pc_branch;
    logic            stall;
  } expect_t;

  logic                  clk;
  logic                  reset;
  instr_u                instruction;
  logic [xlen-1:0]       pc;
  wb_t                   wb;
  id_ex_t                id_ex;
  logic [xlen-1:0]       data1;
  logic [xlen-1:0]       data2;
  logic [xlen-1:0]       imm;
  logic [reg_addr_w-1:0] rd;
  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  control_t              control;
  logic [xlen-1:0]       pc_out;
  logic [xlen-1:0]       pc_branch;
  logic                  pc_src;
  logic                  pc_write;
  logic                  fetch_write;
  logic                  checking;
  int                    checks;
  logic [xlen-1:0]       shadow [32];
  opcode_e               opcodes [9];

  decode_stage #(
    .reg_count (32)
  ) DUT (
    .clk         (clk),
    .reset       (reset),
    .instruction (instruction),
    .pc          (pc),
    .wb          (wb),
    .id_ex       (id_ex),
    .data1       (data1),
    .data2       (data2),
    .imm         (imm),
    .rd          (rd),
    .rs1         (rs1),
    .rs2         (rs2),
    .control     (control),
    .pc_out      (pc_out),
    .pc_branch   (pc_branch),
    .pc_src      (pc_src),
    .pc_write    (pc_write),
    .fetch_write (fetch_write)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string name, input logic [xlen-1:0] expected,
                            input logic [xlen-1:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_index(input string name, input logic [reg_addr_w-1:0] expected,
                             input logic [reg_addr_w-1:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_control(input string name, input control_t expected,
                               input control_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // opcode table, flags are {reg_write, mem_read, mem_write, mem_to_reg, alu_src}
  function automatic control_t control_of(input logic [31:0] w);
    logic [2:0] f3;
    logic       alt;
    f3 = w[14:12];
    // funct7 bit 30 picks sra, and sub only in the register form
    alt = w[30] && ((f3 == 3'b101) || (f3 == 3'b000 && w[6:0] == op));
    case (w[6:0])
      op:      return {r_type, 3'b000, 5'b10000, alt, f3};
      op_imm:  return {i_type, 3'b000, 5'b10001, alt, f3};
      load:    return {i_type, 3'b000, 5'b11011, alu_add};
      store:   return {s_type, 3'b000, 5'b00101, alu_add};
      branch:  return {b_type, f3, 5'b00000, alu_sub};
      lui:     return {u_type, 3'b000, 5'b10001, alu_pass_b};
      auipc:   return {u_type, 3'b000, 5'b10001, alu_add};
      jal:     return {j_type, 3'b000, 5'b10000, alu_add};
      jalr:    return {i_type, 3'b000, 5'b10001, alu_add};
      default: return '0;
    endcase
  endfunction

  function automatic logic [xlen-1:0] imm_of(input logic [31:0] w, input encoding_e enc);
    case (enc)
      i_type:  return {{20{w[31]}}, w[31:20]};
      s_type:  return {{20{w[31]}}, w[31:25], w[11:7]};
      b_type:  return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      u_type:  return {w[31:12], 12'b0};
      j_type:  return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      default: return '0;
    endcase
  endfunction

  function automatic logic taken(input logic [2:0] f3, input logic [xlen-1:0] a,
                                 input logic [xlen-1:0] b);
    logic lt_u;
    logic lt_s;
    lt_u = a < b;
    // signed order is unsigned order with the sign bits flipped
    lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return lt_s;
      3'b101:  return !lt_s;
      3'b110:  return lt_u;
      3'b111:  return !lt_u;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [xlen-1:0] read_operand(input logic [4:0] idx, input wb_t wb_in);
    if (idx == 5'd0) begin
      return '0;
    end
    if (wb_in.reg_write && wb_in.write_id == idx) begin
      return wb_in.write_data;
    end
    return shadow[idx];
  endfunction

  function automatic expect_t expected_outputs(input logic [31:0] w, input logic [xlen-1:0] pc_in,
                                               input wb_t wb_in, input id_ex_t ie);
    expect_t  e;
    control_t raw;
    raw = control_of(w);
    e.imm = imm_of(w, raw.encoding);
    e.data1 = read_operand(w[19:15], wb_in);
    e.data2 = read_operand(w[24:20], wb_in);
    e.stall = ie.mem_read && (ie.rd != 5'd0) && (ie.rd == w[19:15] || ie.rd == w[24:20]);
    e.control = e.stall ? control_t'('0) : raw;
    e.pc_src = (w[6:0] == branch) && !e.stall && taken(w[14:12], e.data1, e.data2);
    e.pc_branch = pc_in + e.imm;
    return e;
  endfunction

  task automatic compare_outputs();
    logic [31:0] w;
    expect_t     e;
    w = instruction;
    e = expected_outputs(w, pc, wb, id_ex);
    check_index("rd", w[11:7], rd);
    check_index("rs1", w[19:15], rs1);
    check_index("rs2", w[24:20], rs2);
    check_word("imm", e.imm, imm);
    check_word("data1", e.data1, data1);
    check_word("data2", e.data2, data2);
    check_control("control", e.control, control);
    check_word("pc_out", pc, pc_out);
    check_word("pc_branch", e.pc_branch, pc_branch);
    check_flag("pc_src", e.pc_src, pc_src);
    check_flag("pc_write", !e.stall, pc_write);
    check_flag("fetch_write", !e.stall, fetch_write);
    checks = checks + 1;
  endtask

  // compare just before the edge, then mirror the write that the edge performs
  always @(posedge clk) begin
    #9;
    if (checking) begin
      compare_outputs();
    end
    if (!reset && wb.reg_write && wb.write_id != '0) begin
      shadow[wb.write_id] = wb.write_data;
    end
  end

  always @(DUT.u_decode_stage_sva.failures) begin
    if (DUT.u_decode_stage_sva.failures != 0) begin
      abort_run("a concurrent assertion in decode_stage_sva failed");
    end
  end

  function automatic logic [31:0] random_instr(input logic [6:0] opc);
    logic [31:0] w;
    logic [2:0]  branch_f3 [6];
    branch_f3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    w = $urandom;
    w[6:0] = opc;
    if (opc == branch) begin
      w[14:12] = branch_f3[$urandom_range(0, 5)];
    end
    return w;
  endfunction

  function automatic wb_t write_port(input int id, input logic [xlen-1:0] value);
    wb_t port;
    port.reg_write = 1'b1;
    port.write_id = id[reg_addr_w-1:0];
    port.write_data = value;
    return port;
  endfunction

  task automatic drive(input logic [31:0] w, input wb_t wb_in, input id_ex_t ie);
    @(posedge clk);
    #1;
    instruction = w;
    pc = $urandom & 32'hffff_fffc;
    wb = wb_in;
    id_ex = ie;
    checking = 1'b1;
  endtask

  initial begin
    logic [31:0]     w;
    id_ex_t          ie;
    logic [xlen-1:0] edges [8];
    void'($urandom(32'h85d3));
    reset = 1'b1;
    instruction = '0;
    pc = '0;
    wb = '0;
    id_ex = '0;
    checking = 1'b0;
    checks = 0;
    opcodes = '{op, op_imm, load, store, branch, lui, auipc, jal, jalr};
    foreach (shadow[i]) begin
      shadow[i] = '0;
    end
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    // every register reads zero after reset
    for (int i = 0; i < 16; i++) begin
      w = random_instr(op);
      w[19:15] = 5'(2 * i);
      w[24:20] = 5'(2 * i + 1);
      drive(w, '0, '0);
    end
    for (int i = 1; i < 32; i++) begin
      drive(random_instr(op_imm), write_port(i, $urandom), '0);
    end
    // x0 ignores writes
    drive(random_instr(op), write_port(0, 32'hdead_beef), '0);
    drive(32'h0000_0033, '0, '0);
    for (int i = 0; i < 16; i++) begin
      w = random_instr(op);
      w[19:15] = 5'(2 * i);
      w[24:20] = 5'(31 - 2 * i);
      drive(w, '0, '0);
    end

    // same-cycle write-through
    for (int i = 0; i < 40; i++) begin
      w = random_instr(branch);
      w[19:15] = 5'($urandom_range(1, 31));
      if (i % 2 == 0) begin
        w[24:20] = w[19:15];
      end
      drive(w, write_port(w[19:15], $urandom), '0);
    end

    // field, immediate and control decode, odd opcodes included
    for (int i = 0; i < 600; i++) begin
      if (i % 50 == 0) begin
        w = random_instr(7'b0001111);
      end else begin
        w = random_instr(opcodes[i % 9]);
      end
      drive(w, '0, '0);
    end

    // signed and unsigned extremes for the branch compares
    edges = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000,
              32'h7fff_ffff, 32'hffff_fffe, 32'h8000_0001, $urandom};
    for (int i = 0; i < 8; i++) begin
      drive(32'h0000_0013, write_port(i + 1, edges[i]), '0);
    end
    for (int i = 0; i < 300; i++) begin
      w = random_instr(branch);
      w[19:15] = 5'($urandom_range(0, 8));
      w[24:20] = (i % 4 == 0) ? w[19:15] : 5'($urandom_range(0, 8));
      drive(w, '0, '0);
    end

    // load-use stall against matching, zero and unrelated rd
    for (int i = 0; i < 200; i++) begin
      w = random_instr(opcodes[$urandom_range(0, 8)]);
      ie.mem_read = ($urandom_range(0, 3) != 0);
      case ($urandom_range(0, 3))
        0:       ie.rd = w[19:15];
        1:       ie.rd = w[24:20];
        2:       ie.rd = '0;
        default: ie.rd = 5'($urandom);
      endcase
      drive(w, '0, ie);
    end

    @(posedge clk);
    #9;
    $display("checks run: %0d", checks);
    $display("Result: PASSED");
    $finish;
  end

  initial begin
    #((num_tests + 16) * 10 * 2);
    abort_run("timeout: the test sequence did not complete in the expected time");
  end

endmodule

//--- sim.f
rv_pkg.sv
decode_control.sv
imm_gen.sv
register_file.sv
hazard_unit.sv
branch_resolve.sv
decode_stage.sv
decode_stage_sva.sv
tb_decode_stage.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - rv_pkg.sv
  - decode_control.sv
  - imm_gen.sv
  - register_file.sv
  - hazard_unit.sv
  - branch_resolve.sv
  - decode_stage.sv
  - target: test
    files:
      - decode_stage_sva.sv
      - tb_decode_stage.sv
